//--- hw/scsi_dma_pkg.sv
//****************************************
// Widths and encodings shared by the SCSI DMA block
// CPU states must stay one contiguous run
//****************************************
package scsi_dma_pkg;

    localparam int BYTE_W = 8;          // Chip data byte
    localparam int WORD_W = 32;         // FIFO longword, four bytes

    typedef enum logic {
        DIR_F2S = 1'b0,                 // Memory to SCSI
        DIR_S2F = 1'b1                  // SCSI to memory
    } xfer_dir_e;

    // Chip port range-checks ST_CPU_REQ..ST_C2S_5 as CPU cycles
    typedef enum logic [4:0] {
        ST_IDLE_RD,                     // Poll S2F side
        ST_IDLE_WR,                     // Poll F2S side
        ST_S2F_1, ST_S2F_2, ST_S2F_3, ST_S2F_4,
        ST_F2S_1, ST_F2S_2, ST_F2S_3, ST_F2S_4,
        ST_CPU_REQ,                     // Start of CPU access
        ST_S2C_1, ST_S2C_2, ST_S2C_3,
        ST_S2C_4, ST_S2C_5, ST_S2C_6,
        ST_C2S_1, ST_C2S_2, ST_C2S_3,
        ST_C2S_4, ST_C2S_5
    } seq_state_e;

endpackage

//--- hw/scsi_dma_if.sv
//****************************************
// Sequencer links to FIFO and chip port
//****************************************
interface fifo_ctrl_if;
    logic s2f;                          // SCSI byte into FIFO
    logic f2s;                          // FIFO byte out to chip
    logic inc_bo;                       // Advance byte pointer
    logic inc_ni;                       // Advance next-in
    logic wr_word;                      // Commit packed longword
    logic inc_no;                       // Advance next-out
    logic rd_word;                      // Release head longword
    logic full;
    logic empty;
    logic bo_eq3;                       // Last byte of word
    logic wr_busy;                      // Commit one clock ago
    logic rd_busy;                      // Release one clock ago

    modport sequencer (output s2f, f2s, inc_bo, inc_ni, wr_word, inc_no, rd_word,
                       input  full, empty, bo_eq3, wr_busy, rd_busy);
    modport fifo      (input  s2f, f2s, inc_bo, inc_ni, wr_word, inc_no, rd_word,
                       output full, empty, bo_eq3, wr_busy, rd_busy);
endinterface

interface chip_strobe_if;
    logic re, we, dack, chip_cs;        // Unregistered chip strobes
    logic cpu2s, s2cpu;                 // CPU cycle direction
    logic set_dsack;                    // Ends the CPU cycle

    modport sequencer (output re, we, dack, chip_cs, cpu2s, s2cpu, set_dsack);
    modport port      (input  re, we, dack, chip_cs, cpu2s, s2cpu);
endinterface

//--- hw/cpu_access_sync.sv
//****************************************
// CPU inputs taken one clock late, DSACK held until request drops
//****************************************
module cpu_access_sync (
    input  logic                            CLK,
    input  logic                            nRESET,
    input  logic                            cpu_req,
    input  logic                            cpu_rw,
    input  scsi_dma_pkg::xfer_dir_e         dma_dir,
    input  logic [scsi_dma_pkg::BYTE_W-1:0] cpu_wdata,
    input  logic                            set_dsack,
    input  logic [scsi_dma_pkg::BYTE_W-1:0] scsi_din,
    output logic                            req_q,
    output logic                            rw_q,
    output scsi_dma_pkg::xfer_dir_e         dir_q,
    output logic [scsi_dma_pkg::BYTE_W-1:0] wdata_q,
    output logic                            dsack_held,
    output logic [scsi_dma_pkg::BYTE_W-1:0] cpu_rdata
);

    always_ff @(posedge CLK or negedge nRESET) begin
        if (!nRESET) begin
            req_q      <= 1'b0;
            rw_q       <= 1'b0;
            dir_q      <= scsi_dma_pkg::DIR_F2S;
            dsack_held <= 1'b0;
        end else begin
            req_q <= cpu_req;                   // Async CPU level
            rw_q  <= cpu_rw;
            dir_q <= dma_dir;
            if (set_dsack)
                dsack_held <= 1'b1;
            else if (!req_q)
                dsack_held <= 1'b0;             // CPU let go
        end
    end

    always_ff @(posedge CLK) begin
        wdata_q <= cpu_wdata;
        if (set_dsack && rw_q)
            cpu_rdata <= scsi_din;              // Chip register byte
    end

endmodule

//--- hw/scsi_sequencer.sv
//****************************************
// One clock per state, outputs decoded from the state
// CPU request beats a new DMA byte at either idle state
//****************************************
module scsi_sequencer (
    input  logic                     CLK,
    input  logic                     nRESET,
    input  logic                     req_q,
    input  logic                     rw_q,
    input  scsi_dma_pkg::xfer_dir_e  dir_q,
    input  logic                     dsack_held,
    input  logic                     scsi_dreq_n,
    fifo_ctrl_if.sequencer           fifo,
    chip_strobe_if.sequencer         strobe,
    output scsi_dma_pkg::seq_state_e state
);

    scsi_dma_pkg::seq_state_e next_state;

    always_ff @(posedge CLK or negedge nRESET) begin
        if (!nRESET)
            state <= scsi_dma_pkg::ST_IDLE_RD;
        else
            state <= next_state;
    end

    always_comb begin
        next_state       = state;
        fifo.s2f         = 1'b0;
        fifo.f2s         = 1'b0;
        fifo.inc_bo      = 1'b0;
        fifo.inc_ni      = 1'b0;
        fifo.wr_word     = 1'b0;
        fifo.inc_no      = 1'b0;
        fifo.rd_word     = 1'b0;
        strobe.re        = 1'b0;
        strobe.we        = 1'b0;
        strobe.dack      = 1'b0;
        strobe.chip_cs   = 1'b0;
        strobe.cpu2s     = 1'b0;
        strobe.s2cpu     = 1'b0;
        strobe.set_dsack = 1'b0;

        case (state)
            scsi_dma_pkg::ST_IDLE_RD: begin
                if (!scsi_dreq_n && !fifo.full && dir_q == scsi_dma_pkg::DIR_S2F &&
                    !req_q && !fifo.wr_busy)
                    next_state = scsi_dma_pkg::ST_S2F_1;
                else if (req_q)
                    next_state = scsi_dma_pkg::ST_CPU_REQ;
                else if (dir_q == scsi_dma_pkg::DIR_F2S)
                    next_state = scsi_dma_pkg::ST_IDLE_WR;
            end
            scsi_dma_pkg::ST_IDLE_WR: begin
                if (!scsi_dreq_n && !fifo.empty && dir_q == scsi_dma_pkg::DIR_F2S &&
                    !req_q && !fifo.rd_busy)
                    next_state = scsi_dma_pkg::ST_F2S_1;
                else if (req_q)
                    next_state = scsi_dma_pkg::ST_CPU_REQ;
                else
                    next_state = scsi_dma_pkg::ST_IDLE_RD;
            end
            scsi_dma_pkg::ST_S2F_1, scsi_dma_pkg::ST_S2F_2, scsi_dma_pkg::ST_S2F_3: begin
                strobe.re   = 1'b1;                 // Chip drives the byte
                strobe.dack = 1'b1;
                fifo.s2f    = 1'b1;
                next_state  = scsi_dma_pkg::seq_state_e'(state + 5'd1);
            end
            scsi_dma_pkg::ST_S2F_4: begin
                fifo.s2f     = 1'b1;
                fifo.inc_bo  = 1'b1;                // Byte lands in its lane
                fifo.inc_ni  = fifo.bo_eq3;
                fifo.wr_word = fifo.bo_eq3;         // Fourth byte commits
                next_state   = scsi_dma_pkg::ST_IDLE_RD;
            end
            scsi_dma_pkg::ST_F2S_1, scsi_dma_pkg::ST_F2S_2, scsi_dma_pkg::ST_F2S_3: begin
                strobe.we   = 1'b1;
                strobe.dack = 1'b1;
                fifo.f2s    = 1'b1;
                next_state  = scsi_dma_pkg::seq_state_e'(state + 5'd1);
            end
            scsi_dma_pkg::ST_F2S_4: begin
                fifo.f2s     = 1'b1;
                fifo.inc_bo  = 1'b1;
                fifo.inc_no  = fifo.bo_eq3;
                fifo.rd_word = fifo.bo_eq3;         // Head word drained
                next_state   = scsi_dma_pkg::ST_IDLE_WR;
            end
            scsi_dma_pkg::ST_CPU_REQ: begin
                strobe.chip_cs = 1'b1;
                strobe.re      = rw_q;
                strobe.s2cpu   = rw_q;
                strobe.we      = !rw_q;
                strobe.cpu2s   = !rw_q;
                next_state     = rw_q ? scsi_dma_pkg::ST_S2C_1 : scsi_dma_pkg::ST_C2S_1;
            end
            scsi_dma_pkg::ST_S2C_1, scsi_dma_pkg::ST_S2C_2, scsi_dma_pkg::ST_S2C_3: begin
                strobe.chip_cs = 1'b1;
                strobe.re      = 1'b1;
                strobe.s2cpu   = 1'b1;
                next_state     = scsi_dma_pkg::seq_state_e'(state + 5'd1);
            end
            scsi_dma_pkg::ST_S2C_4: begin
                strobe.re        = 1'b1;
                strobe.s2cpu     = 1'b1;
                strobe.set_dsack = 1'b1;            // Read byte latched now
                next_state       = scsi_dma_pkg::ST_S2C_5;
            end
            scsi_dma_pkg::ST_S2C_5: begin
                strobe.s2cpu = 1'b1;
                next_state   = scsi_dma_pkg::ST_S2C_6;
            end
            scsi_dma_pkg::ST_S2C_6: begin
                strobe.s2cpu = 1'b1;
                if (!dsack_held)
                    next_state = scsi_dma_pkg::ST_IDLE_RD;
            end
            scsi_dma_pkg::ST_C2S_1, scsi_dma_pkg::ST_C2S_2: begin
                strobe.chip_cs = 1'b1;
                strobe.we      = 1'b1;
                strobe.cpu2s   = 1'b1;
                next_state     = scsi_dma_pkg::seq_state_e'(state + 5'd1);
            end
            scsi_dma_pkg::ST_C2S_3: begin
                strobe.chip_cs   = 1'b1;
                strobe.cpu2s     = 1'b1;
                strobe.set_dsack = 1'b1;
                next_state       = scsi_dma_pkg::ST_C2S_4;
            end
            scsi_dma_pkg::ST_C2S_4: next_state = scsi_dma_pkg::ST_C2S_5;
            scsi_dma_pkg::ST_C2S_5: begin
                if (!dsack_held)                    // Wait for CPU release
                    next_state = scsi_dma_pkg::ST_IDLE_RD;
            end
            default: next_state = scsi_dma_pkg::ST_IDLE_RD;
        endcase
    end

endmodule

//--- hw/longword_fifo.sv
//****************************************
// FIFO_DEPTH a power of two, 2 or more; big-endian lanes
// One byte pointer serves whichever direction is active
//****************************************
module longword_fifo #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                            CLK,
    input  logic                            nRESET,
    input  logic                            host_wr,
    input  logic [scsi_dma_pkg::WORD_W-1:0] host_wdata,
    input  logic                            host_rd,
    input  logic [scsi_dma_pkg::BYTE_W-1:0] scsi_din,
    fifo_ctrl_if.fifo                       ctrl,
    output logic [scsi_dma_pkg::WORD_W-1:0] host_rdata,
    output logic [scsi_dma_pkg::BYTE_W-1:0] dma_byte,
    output logic                            full,
    output logic                            empty
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam int CNT_W = PTR_W + 1;

    logic [scsi_dma_pkg::WORD_W-1:0] mem [FIFO_DEPTH];
    logic [scsi_dma_pkg::WORD_W-1:0] stage;            // Partly packed S2F word
    logic [scsi_dma_pkg::WORD_W-1:0] packed_word;
    logic [PTR_W-1:0]                ni;
    logic [PTR_W-1:0]                no;
    logic [CNT_W-1:0]                count;
    logic [1:0]                      bo;
    logic [4:0]                      lane_lsb;
    logic                            host_push;
    logic                            host_pop;
    logic                            push;
    logic                            pop;

    assign lane_lsb  = {~bo, 3'b000};                   // Pointer 0 is bits 31:24
    assign host_push = host_wr && !full && !ctrl.s2f;   // DMA owns the tail
    assign host_pop  = host_rd && !empty && !ctrl.f2s;  // DMA owns the head
    assign push      = ctrl.inc_ni || host_push;
    assign pop       = ctrl.inc_no || host_pop;

    assign full        = (count == CNT_W'(FIFO_DEPTH));
    assign empty       = (count == '0);
    assign ctrl.full   = full;
    assign ctrl.empty  = empty;
    assign ctrl.bo_eq3 = (bo == 2'd3);
    assign host_rdata  = mem[no];
    assign dma_byte    = host_rdata[lane_lsb +: scsi_dma_pkg::BYTE_W];

    always_comb begin
        packed_word = stage;
        packed_word[lane_lsb +: scsi_dma_pkg::BYTE_W] = scsi_din;
    end

    always_ff @(posedge CLK) begin
        if (ctrl.s2f && ctrl.inc_bo)
            stage <= packed_word;
        if (ctrl.wr_word)
            mem[ni] <= packed_word;                     // Last byte goes straight in
        else if (host_push)
            mem[ni] <= host_wdata;
    end

    always_ff @(posedge CLK or negedge nRESET) begin
        if (!nRESET) begin
            ni           <= '0;
            no           <= '0;
            count        <= '0;
            bo           <= '0;
            ctrl.wr_busy <= 1'b0;
            ctrl.rd_busy <= 1'b0;
        end else begin
            if (push)
                ni <= ni + 1'b1;                        // Wraps at depth
            if (pop)
                no <= no + 1'b1;
            if (push && !pop)
                count <= count + 1'b1;
            else if (pop && !push)
                count <= count - 1'b1;
            if (ctrl.inc_bo)
                bo <= bo + 1'b1;
            ctrl.wr_busy <= ctrl.wr_word;
            ctrl.rd_busy <= ctrl.rd_word;
        end
    end

endmodule

//--- hw/scsi_chip_port.sv
//****************************************
// Chip pins lag the sequencer state by one clock
//****************************************
module scsi_chip_port (
    input  logic                            CLK,
    input  logic                            nRESET,
    input  scsi_dma_pkg::seq_state_e        state,
    input  logic [scsi_dma_pkg::BYTE_W-1:0] wdata_q,
    input  logic [scsi_dma_pkg::BYTE_W-1:0] dma_byte,
    chip_strobe_if.port                     strobe,
    output logic                            scsi_cs,
    output logic                            scsi_re,
    output logic                            scsi_we,
    output logic                            scsi_dack,
    output logic [scsi_dma_pkg::BYTE_W-1:0] scsi_dout
);

    logic cpu_cycle;

    assign cpu_cycle = (state >= scsi_dma_pkg::ST_CPU_REQ) &&
                       (state <= scsi_dma_pkg::ST_C2S_5);

    always_ff @(posedge CLK or negedge nRESET) begin
        if (!nRESET) begin
            scsi_cs   <= 1'b0;
            scsi_re   <= 1'b0;
            scsi_we   <= 1'b0;
            scsi_dack <= 1'b0;
        end else begin
            scsi_cs   <= strobe.chip_cs || (strobe.s2cpu && strobe.re);  // CS spans read
            scsi_re   <= strobe.re;
            scsi_we   <= strobe.we;
            scsi_dack <= strobe.dack;
        end
    end

    // Byte is loaded before the chip sees WE
    always_ff @(posedge CLK) begin
        if (cpu_cycle && strobe.cpu2s)
            scsi_dout <= wdata_q;               // Register write
        else if (!cpu_cycle && strobe.we)
            scsi_dout <= dma_byte;              // FIFO lane
    end

endmodule

//--- hw/scsi_dma_top.sv
//****************************************
// Single chip register, no address decode
//****************************************
module scsi_dma_top #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                            CLK,
    input  logic                            nRESET,
    input  logic                            cpu_req,      // Held until DSACK
    input  logic                            cpu_rw,       // 1 = read
    input  logic [scsi_dma_pkg::BYTE_W-1:0] cpu_wdata,
    output logic [scsi_dma_pkg::BYTE_W-1:0] cpu_rdata,
    output logic                            cpu_dsack,
    input  scsi_dma_pkg::xfer_dir_e         dma_dir,
    input  logic                            host_wr,
    input  logic [scsi_dma_pkg::WORD_W-1:0] host_wdata,
    input  logic                            host_rd,      // Pops the head word
    output logic [scsi_dma_pkg::WORD_W-1:0] host_rdata,
    output logic                            fifo_full,
    output logic                            fifo_empty,
    input  logic                            scsi_dreq_n,  // Active low
    output logic                            scsi_cs,
    output logic                            scsi_re,
    output logic                            scsi_we,
    output logic                            scsi_dack,
    output logic [scsi_dma_pkg::BYTE_W-1:0] scsi_dout,
    input  logic [scsi_dma_pkg::BYTE_W-1:0] scsi_din
);

    logic                            req_q;
    logic                            rw_q;
    scsi_dma_pkg::xfer_dir_e         dir_q;
    logic [scsi_dma_pkg::BYTE_W-1:0] wdata_q;
    logic [scsi_dma_pkg::BYTE_W-1:0] dma_byte;
    logic                            dsack_held;
    scsi_dma_pkg::seq_state_e        state;

    fifo_ctrl_if   fifo_bus ();
    chip_strobe_if strobe_bus ();

    assign cpu_dsack = dsack_held;

    cpu_access_sync u_sync (
        .CLK        (CLK),
        .nRESET     (nRESET),
        .cpu_req    (cpu_req),
        .cpu_rw     (cpu_rw),
        .dma_dir    (dma_dir),
        .cpu_wdata  (cpu_wdata),
        .set_dsack  (strobe_bus.set_dsack),
        .scsi_din   (scsi_din),
        .req_q      (req_q),
        .rw_q       (rw_q),
        .dir_q      (dir_q),
        .wdata_q    (wdata_q),
        .dsack_held (dsack_held),
        .cpu_rdata  (cpu_rdata)
    );

    scsi_sequencer u_seq (
        .CLK         (CLK),
        .nRESET      (nRESET),
        .req_q       (req_q),
        .rw_q        (rw_q),
        .dir_q       (dir_q),
        .dsack_held  (dsack_held),
        .scsi_dreq_n (scsi_dreq_n),
        .fifo        (fifo_bus.sequencer),
        .strobe      (strobe_bus.sequencer),
        .state       (state)
    );

    longword_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .CLK        (CLK),
        .nRESET     (nRESET),
        .host_wr    (host_wr),
        .host_wdata (host_wdata),
        .host_rd    (host_rd),
        .scsi_din   (scsi_din),
        .ctrl       (fifo_bus.fifo),
        .host_rdata (host_rdata),
        .dma_byte   (dma_byte),
        .full       (fifo_full),
        .empty      (fifo_empty)
    );

    scsi_chip_port u_port (
        .CLK       (CLK),
        .nRESET    (nRESET),
        .state     (state),
        .wdata_q   (wdata_q),
        .dma_byte  (dma_byte),
        .strobe    (strobe_bus.port),
        .scsi_cs   (scsi_cs),
        .scsi_re   (scsi_re),
        .scsi_we   (scsi_we),
        .scsi_dack (scsi_dack),
        .scsi_dout (scsi_dout)
    );

endmodule

//--- testbench/tb_clock_gen.sv
//****************************************
// 40 ns clock, nRESET low for 5 cycles
//****************************************
module tb_clock_gen (
    output logic CLK,
    output logic nRESET
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        CLK = 1'b0;
        forever #20 CLK = ~CLK;                 // Half period
    end

    initial begin
        nRESET = 1'b0;
        repeat (5) @(posedge CLK);
        @(negedge CLK);
        nRESET = 1'b1;                          // Released between edges
    end
endmodule

//--- testbench/scsi_dma_tb.sv
//****************************************
// Chip model has one register; S2F bytes come from a fixed-seed stream
//****************************************
module scsi_dma_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int FIFO_DEPTH = 8;
    localparam int TIMEOUT    = 400;            // Clocks per wait

    logic CLK, nRESET;
    logic cpu_req, cpu_rw, cpu_dsack, host_wr, host_rd, fifo_full, fifo_empty;
    logic scsi_cs, scsi_re, scsi_we, scsi_dack;
    logic [7:0] cpu_wdata, cpu_rdata, scsi_dout;
    logic [31:0] host_wdata, host_rdata;
    scsi_dma_pkg::xfer_dir_e dma_dir;
    logic [7:0]  scsi_din    = 8'h00;           // Model drives these two
    logic        scsi_dreq_n = 1'b1;
    logic [7:0]  chip_reg    = 8'h00;
    logic [7:0]  chip_rd_byte = 8'h00;          // Byte returned on CPU reads
    logic [7:0]  s2f_bytes [0:31];
    logic [4:0]  s2f_idx = '0, s2f_len = '0;    // Next byte, end of stream
    logic [7:0]  f2s_got [0:7];
    logic [3:0]  f2s_cnt = '0, f2s_len = '0;
    logic [7:0]  dack_rises = '0;
    logic        prev_dack = 1'b0, prev_re = 1'b0;
    logic [31:0] rng = 32'h5952;
    int          errors = 0, tests = 0, failed = 0;

    tb_clock_gen clk_gen (.CLK(CLK), .nRESET(nRESET));

    scsi_dma_top #(.FIFO_DEPTH(FIFO_DEPTH)) scsi_dma_top_inst (.*);

    always @(negedge CLK) begin : chip_model
        logic [4:0] idx;
        logic [3:0] cnt;
        idx = s2f_idx;
        cnt = f2s_cnt;
        if (scsi_cs && scsi_we)
            chip_reg <= scsi_dout;              // Register write
        if (scsi_dack && !prev_dack) begin
            dack_rises <= dack_rises + 1'b1;
            if (scsi_we && cnt < 4'd8) begin
                f2s_got[cnt[2:0]] <= scsi_dout; // Byte taken from DMA
                cnt = cnt + 1'b1;
            end
        end
        if (prev_dack && prev_re && !scsi_dack)
            idx = idx + 1'b1;                   // Pop on DACK fall
        if (scsi_cs)
            scsi_din <= chip_rd_byte;
        else if (scsi_dack && scsi_re)
            scsi_din <= s2f_bytes[idx];
        scsi_dreq_n <= !(idx < s2f_len || cnt < f2s_len);
        s2f_idx   <= idx;
        f2s_cnt   <= cnt;
        prev_dack <= scsi_dack;
        prev_re   <= scsi_re;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    task automatic fail_value(input string what, input logic [31:0] got, input logic [31:0] exp);
        $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
        errors++;
    endtask

    task automatic end_test(input string name, input int errs_before);
        tests++;
        if (errors == errs_before) begin
            $display("%s: ok", name);
        end else begin
            failed++;
            $display("%s: %0d errors", name, errors - errs_before);
        end
    endtask

    task automatic wait_dsack(input logic level);
        int n;
        n = 0;
        while (cpu_dsack !== level && n < TIMEOUT) begin
            @(negedge CLK);
            n++;
        end
        if (cpu_dsack !== level) begin
            $display("Timed out waiting for cpu_dsack to become %0b", level);
            errors++;
        end
    endtask

    task automatic wait_stream(input logic [4:0] target);
        int n;
        n = 0;
        while (s2f_idx < target && n < TIMEOUT) begin
            @(negedge CLK);
            n++;
        end
        if (s2f_idx < target) begin
            $display("Timed out waiting for the chip to hand over its bytes");
            errors++;
        end
    endtask

    task automatic wait_f2s_done();
        int n;
        n = 0;
        while (!(f2s_cnt == f2s_len && fifo_empty === 1'b1) && n < TIMEOUT) begin
            @(negedge CLK);
            n++;
        end
        if (f2s_cnt != f2s_len || fifo_empty !== 1'b1) begin
            $display("Timed out waiting for the FIFO to drain to the chip");
            errors++;
        end
    endtask

    task automatic load_stream(output logic [31:0] w0, output logic [31:0] w1);
        logic [63:0] both;
        logic [4:0]  pos;
        pos  = s2f_len;
        both = '0;
        for (int k = 0; k < 8; k++) begin
            rng  = xorshift(rng);
            both = {both[55:0], rng[7:0]};      // First byte lands on top
            s2f_bytes[pos] <= rng[7:0];
            pos = pos + 1'b1;
        end
        s2f_len <= pos;
        w0 = both[63:32];
        w1 = both[31:0];
    endtask

    task automatic host_write(input logic [31:0] w);
        host_wr    = 1'b1;
        host_wdata = w;
        @(negedge CLK);
        host_wr = 1'b0;
    endtask

    task automatic host_read_check(input logic [31:0] exp);
        if (fifo_empty !== 1'b0)
            fail_value("fifo_empty before host read", 32'(fifo_empty), 32'd0);
        if (host_rdata !== exp)
            fail_value("host_rdata", host_rdata, exp);
        host_rd = 1'b1;
        @(negedge CLK);
        host_rd = 1'b0;
    endtask

    task automatic cpu_read_check(input string what);
        rng = xorshift(rng);
        chip_rd_byte <= rng[7:0];
        cpu_rw  = 1'b1;
        cpu_req = 1'b1;
        wait_dsack(1'b1);
        if (cpu_rdata !== rng[7:0])
            fail_value(what, 32'(cpu_rdata), 32'(rng[7:0]));
        cpu_req = 1'b0;
        wait_dsack(1'b0);
    endtask

    task automatic test_reset();
        int         e;
        logic [6:0] pins;
        e    = errors;
        pins = {scsi_cs, scsi_re, scsi_we, scsi_dack, cpu_dsack, fifo_empty, fifo_full};
        if (pins !== 7'b0000010)
            fail_value("pins after reset", 32'(pins), 32'b0000010);
        end_test("reset", e);
    endtask

    task automatic test_cpu_write();
        int         e;
        logic [7:0] rises;
        e     = errors;
        rises = dack_rises;
        rng   = xorshift(rng);
        cpu_rw    = 1'b0;
        cpu_wdata = rng[7:0];
        cpu_req   = 1'b1;
        wait_dsack(1'b1);
        if (chip_reg !== rng[7:0])
            fail_value("chip register", 32'(chip_reg), 32'(rng[7:0]));
        if (dack_rises !== rises)
            fail_value("DACK pulses in register write", 32'(dack_rises), 32'(rises));
        cpu_req = 1'b0;
        wait_dsack(1'b0);
        end_test("cpu register write", e);
    endtask

    task automatic test_cpu_read();
        int e;
        e = errors;
        cpu_read_check("cpu_rdata");
        end_test("cpu register read", e);
    endtask

    task automatic test_s2f(input logic cpu_mid);
        int          e;
        logic [4:0]  start;
        logic [31:0] w0, w1;
        e       = errors;
        start   = s2f_len;
        dma_dir = scsi_dma_pkg::DIR_S2F;
        load_stream(w0, w1);
        if (cpu_mid) begin
            wait_stream(start + 5'd2);          // Two bytes in, then the CPU
            cpu_read_check("cpu_rdata during DMA");
        end
        wait_stream(start + 5'd8);
        host_read_check(w0);
        host_read_check(w1);
        if (fifo_empty !== 1'b1)
            fail_value("fifo_empty after S2F", 32'(fifo_empty), 32'd1);
        end_test(cpu_mid ? "cpu access during DMA" : "scsi to fifo", e);
    endtask

    task automatic test_f2s();
        int          e;
        logic [63:0] both;
        e       = errors;
        dma_dir = scsi_dma_pkg::DIR_F2S;
        rng     = xorshift(rng);
        both[63:32] = rng;
        rng     = xorshift(rng);
        both[31:0]  = rng;
        host_write(both[63:32]);
        host_write(both[31:0]);
        f2s_len <= f2s_cnt + 4'd8;
        wait_f2s_done();
        for (int k = 0; k < 8; k++) begin
            if (f2s_got[k] !== both[63:56])     // Big-endian byte order
                fail_value("byte taken by chip", 32'(f2s_got[k]), 32'(both[63:56]));
            both = both << 8;
        end
        end_test("fifo to scsi", e);
    endtask

    initial begin
        cpu_req    = 1'b0;
        cpu_rw     = 1'b0;
        cpu_wdata  = 8'h00;
        dma_dir    = scsi_dma_pkg::DIR_S2F;
        host_wr    = 1'b0;
        host_wdata = '0;
        host_rd    = 1'b0;
        for (int n = 0; n < TIMEOUT && nRESET !== 1'b1; n++)
            @(negedge CLK);
        if (nRESET !== 1'b1) begin
            $display("Timed out waiting for reset to be released");
            errors++;
        end
        @(negedge CLK);
        test_reset();
        test_cpu_write();
        test_cpu_read();
        test_s2f(1'b0);
        test_f2s();
        test_s2f(1'b1);
        $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
        if (errors == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end
endmodule

//--- sources.f
hw/scsi_dma_pkg.sv
hw/scsi_dma_if.sv
hw/cpu_access_sync.sv
hw/scsi_sequencer.sv
hw/longword_fifo.sv
hw/scsi_chip_port.sv
hw/scsi_dma_top.sv
testbench/tb_clock_gen.sv
testbench/scsi_dma_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= scsi_dma_tb
RTL_TOP   ?= scsi_dma_top
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --timescale 1ns/1ps
PASS_MSG  ?= Finished with no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
